// File: test/controller_testdata.txt
// kind start_addr target mtvec mepc pc_in rd_addr wr_addr exp_code exp_addr
// kinds 0 start, 1-4 jal/jalr/branch/mret, 5-6 misaligned, 7-11 sync, 12-13 align, 14-15 wait
00 00001001 00000000 00000000 00000000 00000000 00000000 00000000 0 00001000
01 00000000 00002000 00000100 00000000 00000000 00000000 00000000 0 00002000
01 00000000 00002005 00000100 00000000 00000000 00000000 00000000 0 00002004
02 00000000 00003009 00000100 00000000 00000000 00000000 00000000 0 00003008
03 00000000 0000400c 00000100 00000000 00000000 00000000 00000000 0 0000400c
04 00000000 00000000 00000100 00005550 00000000 00000000 00000000 0 00005550
05 00000000 00006002 00000100 00000000 00000000 00000000 00000000 0 00006002
05 00000000 0000600a 00000201 00000000 00000000 00000000 00000000 0 0000600a
06 00000000 00007006 00000301 00000000 00000000 00000000 00000000 0 00007006
07 00000000 00000000 00000101 00000000 00008000 00000000 00000000 b 00008000
08 00000000 00000000 00000400 00000000 00008010 00000000 00000000 3 00008010
09 00000000 00000000 00000501 00000000 00008020 00000000 00000000 b 00008020
0a 00000000 00000000 00000601 00000000 00008030 00000000 00000000 f 00008030
0b 00000000 00000000 00000700 00000000 00008040 00000000 00000000 f 00008040
0c 00000000 00000000 00000801 00000000 00009000 0000a001 0000b002 4 0000a001
0d 00000000 00000000 00000901 00000000 00009100 0000a101 0000b103 6 0000b103
0c 00000000 00000000 00000a00 00000000 00009200 0000a203 0000b200 4 0000a203
0d 00000000 00000000 00000b00 00000000 00009300 0000a300 0000b301 6 0000b301
0e 00000000 0000c000 00000100 00000000 00009400 0000a400 0000b400 0 0000c000
0f 00000000 0000c104 00000100 00000000 00009500 0000a500 0000b500 0 0000c104
04 00000000 00000000 00000100 0000d000 00000000 00000000 00000000 0 0000d000
07 00000000 00000000 00000c00 00000000 00008050 00000000 00000000 b 00008050
02 00000000 0000e001 00000100 00000000 00000000 00000000 00000000 0 0000e000
ff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0 00000000

// File: rv_core_controller.f
+incdir+include
hdl/ctl_pkg.sv
hdl/ctl_sequencer.sv
hdl/trap_cause_unit.sv
hdl/fetch_target_select.sv
hdl/rv_core_controller.sv
test/tb_clock_gen.sv
test/tb_rv_core_controller.sv

// File: Bender.yml
package:
  name: rv_core_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ctl_pkg.sv
      - hdl/ctl_sequencer.sv
      - hdl/trap_cause_unit.sv
      - hdl/fetch_target_select.sv
      - hdl/rv_core_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock_gen.sv
      - test/tb_rv_core_controller.sv

// File: test/tb_rv_core_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defs.svh"

module tb_rv_core_controller;

    localparam int MAX_SCEN   = 32;
    localparam int WORDS      = 10;
    localparam int W_INIT     = 0;
    localparam int W_NEXT     = 1;
    localparam int W_ACTIVATE = 2;
    localparam int W_ACCESS   = 3;

    wire clk;
    wire reset_n;

    logic                      start;
    logic [`CTL_PC_WIDTH-1:0]  start_addr;
    logic                      mem_read_ack;
    ctl_pkg::decode_info_t     decode;
    ctl_pkg::flow_req_t        flow;
    ctl_pkg::exc_event_t       exc;
    logic                      load_done;
    logic                      store_done;
    logic [`CTL_PC_WIDTH-1:0]  pc_in;
    logic [`CTL_XLEN-1:0]      mem_read_addr;
    logic [`CTL_XLEN-1:0]      mem_write_addr;
    logic [`CTL_XLEN-1:0]      mtvec;
    logic [`CTL_XLEN-1:0]      mepc;
    logic                      fetch_init;
    logic [`CTL_PC_WIDTH-1:0]  fetch_start_addr;
    logic                      fetch_next;
    logic                      exe_enable;
    logic                      data_access_enable;
    ctl_pkg::trap_info_t       trap;
    logic                      paused;

    logic [31:0] testdata [0:MAX_SCEN*WORDS-1];
    logic [31:0] cur [0:WORDS-1];
    integer      seed;
    int          error_count;
    int          check_count;
    int          num_scen;
    int          cycle_count;
    int          cycle_limit;

    tb_clock_gen tb_clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n)
    );

    rv_core_controller rv_core_controller_inst (
        .clk                (clk),
        .reset_n            (reset_n),
        .start              (start),
        .start_addr         (start_addr),
        .mem_read_ack       (mem_read_ack),
        .decode             (decode),
        .flow               (flow),
        .exc                (exc),
        .load_done          (load_done),
        .store_done         (store_done),
        .pc_in              (pc_in),
        .mem_read_addr      (mem_read_addr),
        .mem_write_addr     (mem_write_addr),
        .mtvec              (mtvec),
        .mepc               (mepc),
        .fetch_init         (fetch_init),
        .fetch_start_addr   (fetch_start_addr),
        .fetch_next         (fetch_next),
        .exe_enable         (exe_enable),
        .data_access_enable (data_access_enable),
        .trap               (trap),
        .paused             (paused)
    );

    // ============================================================
    // watchdog
    // ============================================================
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the controller stopped responding after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        assert (actual === expected) else begin
            error_count = error_count + 1;
            $display("FAIL time=%0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // direct mode uses mtvec as is, vectored adds four times the cause
    function automatic logic [31:0] vector_address(input logic [31:0] tvec,
                                                   input logic [31:0] code);
        if (tvec[1:0] == 2'b00) begin
            return tvec;
        end
        return {tvec[31:2], 2'b00} + (code << 2);
    endfunction

    task automatic wait_high(input int sel);
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            @(posedge clk);
            case (sel)
                W_INIT:     hit = fetch_init;
                W_NEXT:     hit = fetch_next;
                W_ACTIVATE: hit = trap.activate;
                default:    hit = data_access_enable;
            endcase
        end
    endtask

    // ack the outstanding fetch, return in the execute cycle
    task automatic answer_fetch();
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(negedge clk);
        mtvec          = cur[3];
        mepc           = cur[4];
        pc_in          = cur[5];
        mem_read_addr  = cur[6];
        mem_write_addr = cur[7];
        repeat (delay) @(negedge clk);
        mem_read_ack = 1'b1;
        wait_high(W_NEXT);
        @(negedge clk);
        mem_read_ack = 1'b0;
    endtask

    task automatic check_trap(input logic check_pc);
        wait_high(W_ACTIVATE);
        check_value("trap.code", trap.code, cur[8]);
        check_value("trap.addr", trap.addr, cur[9]);
        if (check_pc) begin
            check_value("trap.pc", trap.pc, cur[5]);
        end
        wait_high(W_INIT);
        check_value("fetch_start_addr", fetch_start_addr, vector_address(cur[3], cur[8]));
    endtask

    task automatic redirect_to(input logic [31:0] kind);
        flow.jal    = (kind == 1 || kind == 5 || kind >= 14);
        flow.jalr   = (kind == 2);
        flow.branch = (kind == 3 || kind == 6);
        flow.mret   = (kind == 4);
        flow.target = cur[2];
        @(negedge clk);
        flow = '0;
    endtask

    // decode a load or store and let the pending fetch complete
    task automatic enter_data_access(input logic is_store);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(negedge clk);
        decode.valid = 1'b1;
        decode.load  = ~is_store;
        decode.store = is_store;
        @(negedge clk);
        decode = '0;
        repeat (delay) @(negedge clk);
        mem_read_ack = 1'b1;
        @(negedge clk);
        mem_read_ack = 1'b0;
        wait_high(W_ACCESS);
    endtask

    task automatic run_scenario();
        int delay;
        case (cur[0])
            0: begin
                @(negedge clk);
                start_addr = cur[1];
                start      = 1'b1;
                @(negedge clk);
                start = 1'b0;
                wait_high(W_INIT);
                check_value("paused", paused, 0);
                check_value("fetch_start_addr", fetch_start_addr, cur[9]);
            end
            1, 2, 3, 4: begin
                answer_fetch();
                redirect_to(cur[0]);
                wait_high(W_INIT);
                check_value("fetch_start_addr", fetch_start_addr, cur[9]);
            end
            5, 6: begin
                answer_fetch();
                redirect_to(cur[0]);
                check_trap(1'b0);
            end
            7, 8, 9, 10, 11: begin
                answer_fetch();
                @(negedge clk);
                decode.valid = 1'b1;
                @(negedge clk);
                decode = '0;
                exc.ecall            = (cur[0] != 8 && cur[0] != 11);
                exc.ebreak           = (cur[0] != 7);
                exc.store_page_fault = (cur[0] >= 10);
                @(negedge clk);
                exc = '0;
                check_trap(1'b1);
            end
            12, 13: begin
                answer_fetch();
                enter_data_access(cur[0] == 13);
                @(negedge clk);
                exc.alignment = 1'b1;
                @(negedge clk);
                exc = '0;
                check_trap(1'b1);
            end
            default: begin
                // back-pressure, fetch_next held low until the done pulse
                answer_fetch();
                enter_data_access(cur[0] == 14);
                delay = 2 + $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    check_value("fetch_next", fetch_next, 0);
                end
                @(negedge clk);
                store_done = (cur[0] == 14);
                load_done  = (cur[0] != 14);
                @(posedge clk);
                check_value("fetch_next", fetch_next, 1);
                @(negedge clk);
                store_done = 1'b0;
                load_done  = 1'b0;
                redirect_to(cur[0]);
                wait_high(W_INIT);
                check_value("fetch_start_addr", fetch_start_addr, cur[9]);
            end
        endcase
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        seed           = 10753;
        error_count    = 0;
        check_count    = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        start          = 1'b0;
        start_addr     = '0;
        mem_read_ack   = 1'b0;
        decode         = '0;
        flow           = '0;
        exc            = '0;
        load_done      = 1'b0;
        store_done     = 1'b0;
        pc_in          = '0;
        mem_read_addr  = '0;
        mem_write_addr = '0;
        mtvec          = '0;
        mepc           = '0;

        $readmemh("test/controller_testdata.txt", testdata);
        num_scen = 0;
        while (num_scen < MAX_SCEN && testdata[num_scen*WORDS] !== 32'hff) begin
            num_scen = num_scen + 1;
        end
        cycle_limit = 60 * (num_scen + 1);

        @(posedge reset_n);
        @(posedge clk);
        check_value("paused", paused, 1);
        check_value("fetch_init", fetch_init, 0);
        check_value("fetch_next", fetch_next, 0);
        check_value("exe_enable", exe_enable, 0);
        check_value("data_access_enable", data_access_enable, 0);
        check_value("trap.activate", trap.activate, 0);

        for (int n = 0; n < num_scen; n++) begin
            for (int w = 0; w < WORDS; w++) begin
                cur[w] = testdata[n*WORDS + w];
            end
            run_scenario();
        end

        $display("scenarios: %0d, checks: %0d, errors: %0d", num_scen, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 5 cycles, released away from the rising edge
    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defs.svh"

module rv_core_controller (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       start,
    input  wire [`CTL_PC_WIDTH-1:0]   start_addr,
    input  wire                       mem_read_ack,
    input  wire ctl_pkg::decode_info_t decode,
    input  wire ctl_pkg::flow_req_t   flow,
    input  wire ctl_pkg::exc_event_t  exc,
    input  wire                       load_done,
    input  wire                       store_done,
    input  wire [`CTL_PC_WIDTH-1:0]   pc_in,
    input  wire [`CTL_XLEN-1:0]       mem_read_addr,
    input  wire [`CTL_XLEN-1:0]       mem_write_addr,
    input  wire [`CTL_XLEN-1:0]       mtvec,
    input  wire [`CTL_XLEN-1:0]       mepc,
    output logic                      fetch_init,
    output logic [`CTL_PC_WIDTH-1:0]  fetch_start_addr,
    output logic                      fetch_next,
    output logic                      exe_enable,
    output logic                      data_access_enable,
    output ctl_pkg::trap_info_t       trap,
    output logic                      paused
);

    ctl_pkg::ctl_cmd_t cmd;
    logic              pending;

    ctl_sequencer ctl_sequencer_inst (
        .clk                (clk),
        .reset_n            (reset_n),
        .start              (start),
        .mem_read_ack       (mem_read_ack),
        .decode             (decode),
        .flow               (flow),
        .exc                (exc),
        .load_done          (load_done),
        .store_done         (store_done),
        .pending            (pending),
        .cmd                (cmd),
        .fetch_next         (fetch_next),
        .exe_enable         (exe_enable),
        .data_access_enable (data_access_enable),
        .paused             (paused)
    );

    trap_cause_unit trap_cause_unit_inst (
        .clk                (clk),
        .reset_n            (reset_n),
        .cmd                (cmd),
        .exc                (exc),
        .flow               (flow),
        .data_access_enable (data_access_enable),
        .pc_in              (pc_in),
        .mem_read_addr      (mem_read_addr),
        .mem_write_addr     (mem_write_addr),
        .pending            (pending),
        .trap               (trap)
    );

    fetch_target_select fetch_target_select_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .cmd              (cmd),
        .start_addr       (start_addr),
        .flow             (flow),
        .mepc             (mepc),
        .mtvec            (mtvec),
        .trap             (trap),
        .fetch_init       (fetch_init),
        .fetch_start_addr (fetch_start_addr)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_target_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defs.svh"

module fetch_target_select (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire ctl_pkg::ctl_cmd_t    cmd,
    input  wire [`CTL_PC_WIDTH-1:0]   start_addr,
    input  wire ctl_pkg::flow_req_t   flow,
    input  wire [`CTL_XLEN-1:0]       mepc,
    input  wire [`CTL_XLEN-1:0]       mtvec,
    input  wire ctl_pkg::trap_info_t  trap,
    output logic                      fetch_init,
    output logic [`CTL_PC_WIDTH-1:0]  fetch_start_addr
);

    logic [`CTL_XLEN-1:0]     vector_base;
    logic [`CTL_XLEN-1:0]     vector_offset;
    logic [`CTL_PC_WIDTH-1:0] trap_vector;

    // vectored mode, base plus four times the cause
    assign vector_base   = {mtvec[`CTL_XLEN-1:`CTL_MTVEC_MODE_BITS], {`CTL_MTVEC_MODE_BITS{1'b0}}};
    assign vector_offset = {{(`CTL_XLEN - `CTL_CAUSE_BITS - 2){1'b0}}, trap.code, 2'b00};
    assign trap_vector   = (mtvec[`CTL_MTVEC_MODE_BITS-1:0] == `CTL_MTVEC_DIRECT) ?
                           mtvec : vector_base + vector_offset;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_init       <= 1'b0;
            fetch_start_addr <= '0;
        end else begin
            fetch_init <= cmd.pc_init | cmd.redirect | cmd.mret_return | cmd.trap_clear;

            if (cmd.pc_init) begin
                fetch_start_addr <= {start_addr[`CTL_PC_WIDTH-1:1], 1'b0};
            end else if (cmd.redirect) begin
                fetch_start_addr <= {flow.target[`CTL_PC_WIDTH-1:1], 1'b0};
            end else if (cmd.mret_return) begin
                fetch_start_addr <= mepc;
            end else if (cmd.trap_clear) begin
                fetch_start_addr <= trap_vector;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/trap_cause_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defs.svh"

module trap_cause_unit (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire ctl_pkg::ctl_cmd_t    cmd,
    input  wire ctl_pkg::exc_event_t  exc,
    input  wire ctl_pkg::flow_req_t   flow,
    input  wire                       data_access_enable,
    input  wire [`CTL_PC_WIDTH-1:0]   pc_in,
    input  wire [`CTL_XLEN-1:0]       mem_read_addr,
    input  wire [`CTL_XLEN-1:0]       mem_write_addr,
    output logic                      pending,
    output ctl_pkg::trap_info_t       trap
);

    logic page_fault_q;
    logic ecall_q;
    logic ebreak_q;
    logic misalign_q;
    logic align_q;
    logic load_flag;
    logic load_now;

    logic                       activate_q;
    logic [`CTL_CAUSE_BITS-1:0] code_q;
    logic [`CTL_PC_WIDTH-1:0]   pc_q;
    logic [`CTL_PC_WIDTH-1:0]   addr_q;
    logic [`CTL_XLEN-1:0]       read_addr_d1;

    assign pending  = page_fault_q | ecall_q | ebreak_q | misalign_q | align_q;
    assign load_now = load_flag | cmd.load_start;

    assign trap = '{activate: activate_q, code: code_q, pc: pc_q, addr: addr_q};

    // ============================================================
    // sticky event flags and cause priority
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            page_fault_q <= 1'b0;
            ecall_q      <= 1'b0;
            ebreak_q     <= 1'b0;
            misalign_q   <= 1'b0;
            align_q      <= 1'b0;
            load_flag    <= 1'b0;
            activate_q   <= 1'b0;
            code_q       <= '0;
        end else begin
            activate_q <= cmd.trap_enter;

            if (cmd.trap_clear) begin
                page_fault_q <= 1'b0;
                ecall_q      <= 1'b0;
                ebreak_q     <= 1'b0;
                misalign_q   <= 1'b0;
                align_q      <= 1'b0;
            end else begin
                page_fault_q <= page_fault_q | exc.store_page_fault;
                ecall_q      <= ecall_q | exc.ecall;
                ebreak_q     <= ebreak_q | exc.ebreak;
                misalign_q   <= misalign_q | cmd.instr_misalign;
                align_q      <= align_q | exc.alignment;
            end

            // remembers whether the pending access is a load
            if (cmd.access_window | cmd.store_start) begin
                load_flag <= 1'b0;
            end else if (cmd.load_start) begin
                load_flag <= 1'b1;
            end

            if (page_fault_q) begin
                code_q <= `CTL_CAUSE_STORE_PAGE_FAULT;
            end else if (ecall_q) begin
                code_q <= `CTL_CAUSE_ECALL_M;
            end else if (ebreak_q) begin
                code_q <= `CTL_CAUSE_BREAKPOINT;
            end else if (misalign_q) begin
                code_q <= `CTL_CAUSE_INSTR_MISALIGN;
            end else if (align_q) begin
                code_q <= load_flag ? `CTL_CAUSE_LOAD_MISALIGN : `CTL_CAUSE_STORE_MISALIGN;
            end
        end
    end

    // ============================================================
    // faulting pc and address capture
    // ============================================================
    always_ff @(posedge clk) begin
        read_addr_d1 <= mem_read_addr;

        if (data_access_enable) begin
            pc_q <= pc_in;
        end

        if (exc.alignment) begin
            addr_q <= load_now ? read_addr_d1 : mem_write_addr;
        end else if (cmd.instr_misalign) begin
            addr_q <= {flow.target[`CTL_PC_WIDTH-1:1], 1'b0};
        end else if (data_access_enable) begin
            if (flow.jal | flow.jalr | flow.branch) begin
                addr_q <= {flow.target[`CTL_PC_WIDTH-1:1], 1'b0};
            end else begin
                addr_q <= pc_in;
            end
        end
    end

    // one activation per trap entry
    activate_single: assert property (@(posedge clk) disable iff (!reset_n)
        trap.activate |=> !trap.activate);

endmodule

`default_nettype wire

// File: hdl/ctl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   start,
    input  wire                   mem_read_ack,
    input  wire ctl_pkg::decode_info_t decode,
    input  wire ctl_pkg::flow_req_t    flow,
    input  wire ctl_pkg::exc_event_t   exc,
    input  wire                   load_done,
    input  wire                   store_done,
    input  wire                   pending,
    output ctl_pkg::ctl_cmd_t     cmd,
    output logic                  fetch_next,
    output logic                  exe_enable,
    output logic                  data_access_enable,
    output logic                  paused
);

    localparam int S_INIT          = 0;
    localparam int S_INIT_WAIT     = 1;
    localparam int S_FETCH         = 2;
    localparam int S_DECODE        = 3;
    localparam int S_EXECUTE       = 4;
    localparam int S_DECODE_DATA   = 5;
    localparam int S_STORE         = 6;
    localparam int S_STORE_WAIT    = 7;
    localparam int S_LOAD          = 8;
    localparam int S_LOAD_WAIT     = 9;
    localparam int S_EXCEPTION     = 10;
    localparam int S_EXC_REINIT    = 11;
    localparam int NUM_STATES      = 12;

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] state_next;

    logic fetch_active;
    logic first_exe;
    logic access_block_q;
    logic decode_valid_d1;
    logic mem_read_ack_d1;
    logic resume_d1;
    logic resume_d2;

    logic access_block;
    logic resume;
    logic exc_now;
    logic flow_taken;
    logic target_misalign;
    logic restart;

    assign exc_now = exc.store_page_fault | exc.ecall | exc.ebreak | exc.alignment;
    assign flow_taken = flow.jal | flow.jalr | flow.branch;
    assign target_misalign = flow_taken & flow.target[1];
    assign restart = cmd.pc_init | cmd.redirect | cmd.mret_return | cmd.trap_clear;

    // ============================================================
    // state and bookkeeping registers
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= '0;
            state[S_INIT]   <= 1'b1;
            fetch_active    <= 1'b0;
            first_exe       <= 1'b0;
            access_block_q  <= 1'b0;
            decode_valid_d1 <= 1'b0;
            mem_read_ack_d1 <= 1'b0;
            resume_d1       <= 1'b0;
            resume_d2       <= 1'b0;
        end else begin
            state           <= state_next;
            access_block_q  <= access_block;
            decode_valid_d1 <= decode.valid;
            mem_read_ack_d1 <= mem_read_ack;
            resume_d1       <= resume;
            resume_d2       <= resume_d1;

            // a fetch stays outstanding until memory accepts it
            if (fetch_next) begin
                fetch_active <= 1'b1;
            end else if (mem_read_ack) begin
                fetch_active <= 1'b0;
            end

            // no data access until something has executed since restart
            if (restart) begin
                first_exe <= 1'b0;
            end else if (exe_enable) begin
                first_exe <= 1'b1;
            end
        end
    end

    // ============================================================
    // next state and command decode
    // ============================================================
    always_comb begin
        state_next         = '0;
        cmd                = '0;
        fetch_next         = 1'b0;
        exe_enable         = 1'b0;
        data_access_enable = 1'b0;
        paused             = 1'b0;
        access_block       = 1'b0;
        resume             = 1'b0;

        case (1'b1)
            state[S_INIT]: begin
                paused = 1'b1;
                if (start) begin
                    cmd.pc_init = 1'b1;
                    state_next[S_INIT_WAIT] = 1'b1;
                end else begin
                    state_next[S_INIT] = 1'b1;
                end
            end
            state[S_INIT_WAIT]: state_next[S_FETCH] = 1'b1;
            state[S_FETCH]:     state_next[S_DECODE] = 1'b1;
            state[S_DECODE]: begin
                if (mem_read_ack) begin
                    fetch_next = 1'b1;
                    state_next[S_EXECUTE] = 1'b1;
                end else begin
                    state_next[S_DECODE] = 1'b1;
                end
            end
            state[S_EXECUTE]: begin
                cmd.access_window  = 1'b1;
                data_access_enable = first_exe & ~access_block_q;
                if (target_misalign) begin
                    cmd.instr_misalign = 1'b1;
                    state_next[S_EXCEPTION] = 1'b1;
                end else if ((exc_now | pending) & data_access_enable) begin
                    state_next[S_EXCEPTION] = 1'b1;
                end else if (flow_taken | flow.mret) begin
                    cmd.redirect    = flow_taken;
                    cmd.mret_return = flow.mret;
                    state_next[S_INIT_WAIT] = 1'b1;
                end else begin
                    state_next[S_DECODE_DATA] = 1'b1;
                end
            end
            state[S_DECODE_DATA]: begin
                exe_enable   = decode.valid | decode_valid_d1 | resume_d2;
                access_block = ~exe_enable;
                if (decode.store) begin
                    state_next[S_STORE] = 1'b1;
                end else if (decode.load) begin
                    state_next[S_LOAD] = 1'b1;
                end else begin
                    fetch_next = mem_read_ack | mem_read_ack_d1;
                    state_next[S_EXECUTE] = 1'b1;
                end
            end
            state[S_STORE]: begin
                // wait for the instruction fetch to clear the bus
                if (!fetch_active) begin
                    data_access_enable = 1'b1;
                    cmd.store_start    = 1'b1;
                    state_next[S_STORE_WAIT] = 1'b1;
                end else begin
                    state_next[S_STORE] = 1'b1;
                end
            end
            state[S_STORE_WAIT]: begin
                if (exc.alignment) begin
                    state_next[S_EXCEPTION] = 1'b1;
                end else if (store_done) begin
                    fetch_next   = 1'b1;
                    access_block = 1'b1;
                    resume       = 1'b1;
                    state_next[S_EXECUTE] = 1'b1;
                end else begin
                    state_next[S_STORE_WAIT] = 1'b1;
                end
            end
            state[S_LOAD]: begin
                if (!fetch_active) begin
                    data_access_enable = 1'b1;
                    cmd.load_start     = 1'b1;
                    state_next[S_LOAD_WAIT] = 1'b1;
                end else begin
                    state_next[S_LOAD] = 1'b1;
                end
            end
            state[S_LOAD_WAIT]: begin
                if (exc.alignment) begin
                    state_next[S_EXCEPTION] = 1'b1;
                end else if (load_done) begin
                    fetch_next   = 1'b1;
                    access_block = 1'b1;
                    resume       = 1'b1;
                    state_next[S_EXECUTE] = 1'b1;
                end else begin
                    state_next[S_LOAD_WAIT] = 1'b1;
                end
            end
            state[S_EXCEPTION]: begin
                cmd.trap_enter = 1'b1;
                state_next[S_EXC_REINIT] = 1'b1;
            end
            state[S_EXC_REINIT]: begin
                // cause code is settled here, selector jumps to the vector
                cmd.trap_clear = 1'b1;
                state_next[S_INIT_WAIT] = 1'b1;
            end
            default: state_next[S_INIT] = 1'b1;
        endcase
    end

    state_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(state));

    load_store_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(cmd.load_start && cmd.store_start));

endmodule

`default_nettype wire

// File: hdl/ctl_pkg.sv
`default_nettype none

`include "ctl_defs.svh"

package ctl_pkg;

    // one cycle per decoded instruction
    typedef struct packed {
        logic valid;
        logic load;
        logic store;
    } decode_info_t;

    // control transfer request, flags mutually exclusive
    typedef struct packed {
        logic                     jal;
        logic                     jalr;
        logic                     branch;
        logic                     mret;
        logic [`CTL_PC_WIDTH-1:0] target;
    } flow_req_t;

    // exception event pulses
    typedef struct packed {
        logic store_page_fault;
        logic ecall;
        logic ebreak;
        logic alignment;
    } exc_event_t;

    // sequencer commands to the trap unit and the fetch selector
    typedef struct packed {
        logic pc_init;
        logic redirect;
        logic mret_return;
        logic trap_enter;
        logic trap_clear;
        logic instr_misalign;
        logic load_start;
        logic store_start;
        logic access_window;
    } ctl_cmd_t;

    typedef struct packed {
        logic                       activate;
        logic [`CTL_CAUSE_BITS-1:0] code;
        logic [`CTL_PC_WIDTH-1:0]   pc;
        logic [`CTL_PC_WIDTH-1:0]   addr;
    } trap_info_t;

endpackage

`default_nettype wire

// File: include/ctl_defs.svh
`ifndef CTL_DEFS_SVH
`define CTL_DEFS_SVH

// datapath widths
`define CTL_PC_WIDTH   32
`define CTL_XLEN       32
`define CTL_CAUSE_BITS 4

// ============================================================
// synchronous exception cause codes (mcause, interrupt bit 0)
// ============================================================
`define CTL_CAUSE_INSTR_MISALIGN   4'd0
`define CTL_CAUSE_BREAKPOINT       4'd3
`define CTL_CAUSE_LOAD_MISALIGN    4'd4
`define CTL_CAUSE_STORE_MISALIGN   4'd6
`define CTL_CAUSE_ECALL_M          4'd11
`define CTL_CAUSE_STORE_PAGE_FAULT 4'd15

// mtvec mode field
`define CTL_MTVEC_MODE_BITS 2
`define CTL_MTVEC_DIRECT    2'b00

`endif
